/* include/sdmac_consts.svh */
/* Register map and sizing constants for the SCSI DMA controller
   Register offsets are byte addresses on a 12-bit APB bus */
`ifndef SDMAC_CONSTS_SVH
`define SDMAC_CONSTS_SVH

// FIFO between the SCSI port and the DMA engine
`define SDMAC_FIFO_DEPTH 8

// Register offsets
`define SDMAC_WTC     12'h004
`define SDMAC_CNTR    12'h008
`define SDMAC_ACR     12'h00C
`define SDMAC_ST_DMA  12'h010
`define SDMAC_CLR_INT 12'h018
`define SDMAC_ISTR    12'h01C
`define SDMAC_SP_DMA  12'h03C

// Memory window into the local RAM
`define SDMAC_WIN_BASE  12'h400
`define SDMAC_WIN_WORDS 256

// ISTR bit positions
`define SDMAC_ISTR_FE    0
`define SDMAC_ISTR_FF    1
`define SDMAC_ISTR_INT_P 4
`define SDMAC_ISTR_E_INT 5
`define SDMAC_ISTR_INTS  6
`define SDMAC_ISTR_INT_F 7

// CNTR interrupt enable
`define SDMAC_CNTR_INTEN 2

`endif

/* src/sdmac_pkg.sv */
/* Shared types for the SCSI DMA subsystem
   RAM index is 8 bits wide so the local RAM holds 256 words */
package sdmac_pkg;

  // Data word on every path
  typedef logic [31:0] word_t;

  // Word index into the local RAM
  typedef logic [7:0] ram_addr_t;

  // APB request from the host
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    word_t       pwdata;
  } apb_req_t;

  // APB response back to the host
  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // RAM request, held until granted
  typedef struct packed {
    logic      valid;
    logic      we;
    ram_addr_t addr;
    word_t     wdata;
  } mem_req_t;

  // RAM read return
  typedef struct packed {
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

  // SCSI side input word
  typedef struct packed {
    logic  valid;
    word_t data;
  } scsi_word_t;

endpackage

/* src/sdmac_regs.sv */
/* APB register block and memory window master
   Register accesses take two cycles, window accesses wait for the RAM arbiter
   Addresses outside the map complete with pslverr */
`include "sdmac_consts.svh"

module sdmac_regs import sdmac_pkg::*; (
  input  logic       clk,
  input  logic       RESET_,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  output logic       st_dma,
  output logic       sp_dma,
  output logic       istr_rd,
  output logic       clr_int,
  output logic       intena,
  output word_t      acr,
  output word_t      wtc,
  input  word_t      eng_addr,
  input  word_t      eng_count,
  input  logic       active,
  input  logic [7:0] istr,
  output mem_req_t   win_req,
  input  logic       win_gnt,
  input  mem_rsp_t   win_rsp
);

  logic  setup, access, in_win, reg_hit, reg_wr, track;
  logic  track_q, win_done_q, win_rd_pend_q;
  word_t cntr_q, acr_q, wtc_q, rd_q, reg_rdata;

  // APB phases
  assign setup  = apb_req.psel && !apb_req.penable;
  assign access = apb_req.psel && apb_req.penable;

  // Window decode covers 256 words above the base
  assign in_win = (apb_req.paddr >= `SDMAC_WIN_BASE) &&
                  (apb_req.paddr < `SDMAC_WIN_BASE + 4 * `SDMAC_WIN_WORDS);
  assign reg_wr = access && apb_req.pwrite && !in_win;

  // One-cycle strobes from the access phase
  assign st_dma  = reg_wr && (apb_req.paddr == `SDMAC_ST_DMA);
  assign sp_dma  = reg_wr && (apb_req.paddr == `SDMAC_SP_DMA);
  assign clr_int = reg_wr && (apb_req.paddr == `SDMAC_CLR_INT);
  // Status snapshot is taken in the setup phase
  assign istr_rd = setup && !apb_req.pwrite && (apb_req.paddr == `SDMAC_ISTR);

  assign intena = cntr_q[`SDMAC_CNTR_INTEN];
  assign acr    = acr_q;
  assign wtc    = wtc_q;

  // Follow the engine while it runs and one cycle after it stops
  assign track = active || track_q;

  always_ff @(posedge clk) begin
    if (!RESET_) begin
      cntr_q  <= '0;
      acr_q   <= '0;
      wtc_q   <= '0;
      track_q <= 1'b0;
    end else begin
      track_q <= active;
      if (track) begin
        acr_q <= eng_addr;
        wtc_q <= eng_count;
      end
      // Host write wins over the engine copy
      if (reg_wr) begin
        case (apb_req.paddr)
          `SDMAC_CNTR: cntr_q <= apb_req.pwdata;
          `SDMAC_ACR:  acr_q  <= apb_req.pwdata;
          `SDMAC_WTC:  wtc_q  <= apb_req.pwdata;
          default: ;
        endcase
      end
    end
  end

  // Register read mux and map check
  always_comb begin
    reg_rdata = '0;
    reg_hit   = 1'b1;
    case (apb_req.paddr)
      `SDMAC_CNTR:    reg_rdata = cntr_q;
      `SDMAC_ACR:     reg_rdata = track ? eng_addr : acr_q;
      `SDMAC_WTC:     reg_rdata = track ? eng_count : wtc_q;
      `SDMAC_ISTR:    reg_rdata = {24'b0, istr};
      `SDMAC_ST_DMA,
      `SDMAC_SP_DMA,
      `SDMAC_CLR_INT: reg_rdata = '0;
      default:        reg_hit   = 1'b0;
    endcase
  end

  // Window request stays up until granted
  assign win_req.valid = access && in_win && !win_done_q && !win_rd_pend_q;
  assign win_req.we    = apb_req.pwrite;
  assign win_req.addr  = ram_addr_t'((apb_req.paddr - `SDMAC_WIN_BASE) >> 2);
  assign win_req.wdata = apb_req.pwdata;

  always_ff @(posedge clk) begin
    if (!RESET_) begin
      win_done_q    <= 1'b0;
      win_rd_pend_q <= 1'b0;
    end else begin
      if (win_req.valid && win_gnt) begin
        // Writes finish next cycle, reads wait for rvalid
        win_done_q    <= apb_req.pwrite;
        win_rd_pend_q <= !apb_req.pwrite;
      end
      if (win_rd_pend_q && win_rsp.rvalid) begin
        win_rd_pend_q <= 1'b0;
        win_done_q    <= 1'b1;
      end
      if (access && in_win && win_done_q)
        win_done_q <= 1'b0;
    end
  end

  // Read data held for the completing access phase
  always_ff @(posedge clk) begin
    if (win_rd_pend_q && win_rsp.rvalid)
      rd_q <= win_rsp.rdata;
  end

  assign apb_rsp.pready  = access && (in_win ? win_done_q : 1'b1);
  assign apb_rsp.pslverr = access && !in_win && !reg_hit;
  assign apb_rsp.prdata  = in_win ? rd_q : reg_rdata;

  // A stalled access phase keeps its request fields until pready
  assert property (@(posedge clk) disable iff (!RESET_)
    (access && !apb_rsp.pready) |=>
      (access && $stable(apb_req.pwrite) && $stable(apb_req.paddr) &&
       $stable(apb_req.pwdata)))
    else $error("APB request changed while waiting for pready");

endmodule

/* src/sdmac_istr.sv */
/* Interrupt status register with snapshot on status read
   FE resets to 1, clear-interrupt zeroes only the interrupt bits */
`include "sdmac_consts.svh"

module sdmac_istr (
  input  logic       clk,
  input  logic       RESET_,
  input  logic       istr_rd,
  input  logic       clr_int,
  input  logic       intena,
  input  logic       dma_done,
  input  logic       fifo_full,
  input  logic       fifo_empty,
  output logic [7:0] istr,
  output logic       int_n
);

  logic int_pending;
  logic ff_q, fe_q, int_f_q, ints_q, e_int_q, int_p_q;

  // Sticky pending flag, a new done wins over a clear
  always_ff @(posedge clk) begin
    if (!RESET_)
      int_pending <= 1'b0;
    else if (dma_done)
      int_pending <= 1'b1;
    else if (clr_int)
      int_pending <= 1'b0;
  end

  // Snapshot of FIFO flags and interrupt state
  always_ff @(posedge clk) begin
    if (!RESET_) begin
      ff_q    <= 1'b0;
      fe_q    <= 1'b1;
      int_f_q <= 1'b0;
      ints_q  <= 1'b0;
      e_int_q <= 1'b0;
      int_p_q <= 1'b0;
    end else begin
      if (istr_rd) begin
        ff_q    <= fifo_full;
        fe_q    <= fifo_empty;
        int_f_q <= int_pending;
        ints_q  <= int_pending;
        e_int_q <= int_pending;
        // INT_P only when the host has enabled interrupts
        int_p_q <= int_pending && intena;
      end
      if (clr_int) begin
        int_f_q <= 1'b0;
        ints_q  <= 1'b0;
        e_int_q <= 1'b0;
        int_p_q <= 1'b0;
      end
    end
  end

  // Unused bits read as zero
  always_comb begin
    istr                     = '0;
    istr[`SDMAC_ISTR_FE]    = fe_q;
    istr[`SDMAC_ISTR_FF]    = ff_q;
    istr[`SDMAC_ISTR_INT_P] = int_p_q;
    istr[`SDMAC_ISTR_E_INT] = e_int_q;
    istr[`SDMAC_ISTR_INTS]  = ints_q;
    istr[`SDMAC_ISTR_INT_F] = int_f_q;
  end

  // Active low interrupt to the host
  assign int_n = !(int_pending && intena);

endmodule

/* src/dma_fifo.sv */
/* Synchronous word FIFO between the SCSI port and the DMA engine
   DEPTH must be a power of two, head word falls through on data */
`include "sdmac_consts.svh"

module dma_fifo import sdmac_pkg::*; #(
  parameter int DEPTH = `SDMAC_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       RESET_,
  input  scsi_word_t scsi_in,
  output logic       scsi_ready,
  input  logic       pop,
  output word_t      data,
  output logic       full,
  output logic       empty
);

  localparam int AW = $clog2(DEPTH);

  word_t          mem [DEPTH];
  logic [AW:0]    wr_ptr, rd_ptr, wr_nxt, rd_nxt;
  logic           push, full_q;

  // Accept a word only while there is room
  assign scsi_ready = !full_q;
  assign push       = scsi_in.valid && !full_q;

  // Extra pointer bit tells full from empty
  assign wr_nxt = push ? wr_ptr + 1'b1 : wr_ptr;
  assign rd_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;

  always_ff @(posedge clk) begin
    if (!RESET_) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full_q <= 1'b0;
    end else begin
      wr_ptr <= wr_nxt;
      rd_ptr <= rd_nxt;
      // Full when the pointers differ only in the wrap bit
      full_q <= (wr_nxt[AW] != rd_nxt[AW]) && (wr_nxt[AW-1:0] == rd_nxt[AW-1:0]);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr[AW-1:0]] <= scsi_in.data;
  end

  assign data  = mem[rd_ptr[AW-1:0]];
  assign full  = full_q;
  assign empty = (wr_ptr == rd_ptr);

  // The engine never pops an empty FIFO
  assert property (@(posedge clk) disable iff (!RESET_) pop |-> !empty)
    else $error("FIFO popped while empty");

endmodule

/* src/dma_engine.sv */
/* Device-to-memory DMA engine, one word per RAM grant
   ACR is a RAM word index, a zero count finishes at once
   Stop ends the transfer without a done pulse */
`include "sdmac_consts.svh"

module dma_engine import sdmac_pkg::*; (
  input  logic     clk,
  input  logic     RESET_,
  input  logic     st_dma,
  input  logic     sp_dma,
  input  word_t    acr,
  input  word_t    wtc,
  input  word_t    fifo_data,
  input  logic     fifo_empty,
  output logic     pop,
  output mem_req_t mem_req,
  input  logic     gnt,
  output logic     dma_done,
  output word_t    eng_addr,
  output word_t    eng_count,
  output logic     active
);

  word_t addr_q, count_q;
  logic  active_q, done_q;

  // Write request with the FIFO head while there is data
  assign mem_req.valid = active_q && !fifo_empty;
  assign mem_req.we    = 1'b1;
  assign mem_req.addr  = ram_addr_t'(addr_q);
  assign mem_req.wdata = fifo_data;

  // Word is consumed on the grant
  assign pop = mem_req.valid && gnt;

  always_ff @(posedge clk) begin
    if (!RESET_) begin
      addr_q   <= '0;
      count_q  <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (pop) begin
        addr_q  <= addr_q + 32'd1;
        count_q <= count_q - 32'd1;
        // Last word written
        if (count_q == 32'd1) begin
          active_q <= 1'b0;
          done_q   <= !sp_dma;
        end
      end
      if (sp_dma)
        active_q <= 1'b0;
      // Start loads counters, zero count ends right away
      if (st_dma) begin
        addr_q   <= acr;
        count_q  <= wtc;
        active_q <= (wtc != '0);
        done_q   <= (wtc == '0);
      end
    end
  end

  assign dma_done  = done_q;
  assign eng_addr  = addr_q;
  assign eng_count = count_q;
  assign active    = active_q;

  // Pops happen only on granted cycles
  assert property (@(posedge clk) disable iff (!RESET_) pop |-> gnt)
    else $error("FIFO pop without a RAM grant");

  // Transfers must stay inside the local RAM
  assert property (@(posedge clk) disable iff (!RESET_)
    mem_req.valid |-> (addr_q < `SDMAC_WIN_WORDS))
    else $error("DMA address beyond local RAM");

endmodule

/* src/mem_arbiter.sv */
/* Two-master round-robin arbiter for the local RAM port
   Read data is steered to the master that issued the read */
module mem_arbiter import sdmac_pkg::*; (
  input  logic     clk,
  input  logic     RESET_,
  input  mem_req_t dma_req,
  input  mem_req_t win_req,
  output logic     dma_gnt,
  output logic     win_gnt,
  output mem_req_t ram_req,
  input  mem_rsp_t ram_rsp,
  output mem_rsp_t dma_rsp,
  output mem_rsp_t win_rsp
);

  logic last_win_q, owner_win_q;

  // DMA wins if alone or if the window went last
  assign dma_gnt = dma_req.valid && (!win_req.valid || last_win_q);
  assign win_gnt = win_req.valid && !dma_gnt;

  // Only the granted request reaches the RAM
  always_comb begin
    ram_req = '0;
    if (dma_gnt)
      ram_req = dma_req;
    else if (win_gnt)
      ram_req = win_req;
  end

  always_ff @(posedge clk) begin
    if (!RESET_) begin
      last_win_q  <= 1'b0;
      owner_win_q <= 1'b0;
    end else begin
      if (dma_gnt || win_gnt)
        last_win_q <= win_gnt;
      // Owner of the read that returns next cycle
      if (ram_req.valid && !ram_req.we)
        owner_win_q <= win_gnt;
    end
  end

  always_comb begin
    dma_rsp        = ram_rsp;
    win_rsp        = ram_rsp;
    dma_rsp.rvalid = ram_rsp.rvalid && !owner_win_q;
    win_rsp.rvalid = ram_rsp.rvalid && owner_win_q;
  end

  assert property (@(posedge clk) disable iff (!RESET_) !(dma_gnt && win_gnt))
    else $error("Both RAM masters granted");

endmodule

/* src/local_ram.sv */
/* Single-port local RAM, 256 words
   Read data and rvalid arrive one cycle after the request */
module local_ram import sdmac_pkg::*; (
  input  logic     clk,
  input  mem_req_t ram_req,
  output mem_rsp_t ram_rsp
);

  word_t mem [2 ** $bits(ram_addr_t)];

  always_ff @(posedge clk) begin
    // Write port
    if (ram_req.valid && ram_req.we)
      mem[ram_req.addr] <= ram_req.wdata;
    // Registered read
    ram_rsp.rvalid <= ram_req.valid && !ram_req.we;
    if (ram_req.valid && !ram_req.we)
      ram_rsp.rdata <= mem[ram_req.addr];
  end

endmodule

/* src/sdmac_top.sv */
/* SCSI DMA subsystem top, APB host port and SCSI word input
   DMA response path is unused since the engine only writes */
module sdmac_top import sdmac_pkg::*; (
  input  logic       clk,
  input  logic       RESET_,
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  input  scsi_word_t scsi_in,
  output logic       scsi_ready,
  output logic       int_n
);

  logic       st_dma, sp_dma, istr_rd, clr_int, intena, active, dma_done, pop;
  logic       fifo_full, fifo_empty, dma_gnt, win_gnt;
  logic [7:0] istr;
  word_t      acr, wtc, eng_addr, eng_count, fifo_data;
  mem_req_t   dma_req, win_req, ram_req;
  mem_rsp_t   win_rsp, ram_rsp;

  sdmac_regs u_regs (.clk, .RESET_, .apb_req, .apb_rsp, .st_dma, .sp_dma, .istr_rd,
    .clr_int, .intena, .acr, .wtc, .eng_addr, .eng_count, .active, .istr,
    .win_req, .win_gnt, .win_rsp);

  sdmac_istr u_istr (.clk, .RESET_, .istr_rd, .clr_int, .intena, .dma_done,
    .fifo_full, .fifo_empty, .istr, .int_n);

  dma_fifo u_fifo (.clk, .RESET_, .scsi_in, .scsi_ready, .pop, .data(fifo_data),
    .full(fifo_full), .empty(fifo_empty));

  dma_engine u_engine (.clk, .RESET_, .st_dma, .sp_dma, .acr, .wtc, .fifo_data,
    .fifo_empty, .pop, .mem_req(dma_req), .gnt(dma_gnt), .dma_done, .eng_addr,
    .eng_count, .active);

  // Engine writes only, so its read return is left open
  mem_arbiter u_arbiter (.clk, .RESET_, .dma_req, .win_req, .dma_gnt, .win_gnt,
    .ram_req, .ram_rsp, .dma_rsp(), .win_rsp);

  local_ram u_ram (.clk, .ram_req, .ram_rsp);

endmodule

/* verification/tb_sdmac.sv */
/* Directed testbench for the SCSI DMA subsystem
   Inputs change 1 ns after the rising edge, outputs are read after it settles
   Any failed check or timeout stops the run at once */
`include "sdmac_consts.svh"

module tb_sdmac import sdmac_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // Cycle limit for every wait loop
  localparam int    TIMEOUT = 200;
  localparam word_t INTEN   = 32'h1 << `SDMAC_CNTR_INTEN;

  logic        clk;
  logic        RESET_;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  scsi_word_t  scsi_in;
  logic        scsi_ready;
  logic        int_n;
  logic [31:0] lfsr;
  // Words sent into the FIFO, oldest first
  word_t       sent [$];
  // Window locations written by the window test
  logic [7:0]  win_idx [4] = '{8'h80, 8'h81, 8'hC3, 8'hFF};
  word_t       win_words [4];

  sdmac_top u_sdmac_top (.clk, .RESET_, .apb_req, .apb_rsp, .scsi_in, .scsi_ready, .int_n);

  always #2 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per data bit
  task automatic rand_word(output word_t w);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic check(input string name, input word_t expected, input word_t actual);
    if (expected !== actual)
      stop_on_failure($sformatf("Error in %s: expected %h, actual %h", name, expected, actual));
  endtask

  // Byte address of a RAM word inside the window
  function automatic logic [11:0] win_addr(input logic [7:0] idx);
    return `SDMAC_WIN_BASE + {2'b00, idx, 2'b00};
  endfunction

  // Expected ISTR from its bit rules, flags covers E_INT INTS INT_F
  function automatic word_t istr_value(input logic fe, input logic ff, input logic int_p,
                                       input logic flags);
    word_t v;
    v                     = '0;
    v[`SDMAC_ISTR_FE]    = fe;
    v[`SDMAC_ISTR_FF]    = ff;
    v[`SDMAC_ISTR_INT_P] = int_p;
    v[`SDMAC_ISTR_E_INT] = flags;
    v[`SDMAC_ISTR_INTS]  = flags;
    v[`SDMAC_ISTR_INT_F] = flags;
    return v;
  endfunction

  // Setup phase, then access phase until pready
  task automatic apb_access(input logic write, input logic [11:0] addr, input word_t wdata,
                            output word_t rdata);
    int n;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    n = 0;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      n++;
      if (n > TIMEOUT)
        stop_on_failure($sformatf("APB access to %h never completed", addr));
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    check($sformatf("pslverr at %h", addr), 32'h0, apb_rsp.pslverr);
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input word_t wdata);
    word_t unused;
    apb_access(1'b1, addr, wdata, unused);
  endtask

  task automatic apb_read(input logic [11:0] addr, output word_t rdata);
    apb_access(1'b0, addr, '0, rdata);
  endtask

  // Holds valid until the FIFO takes the word
  task automatic scsi_push(input word_t w);
    int n;
    scsi_in.valid = 1'b1;
    scsi_in.data  = w;
    n = 0;
    @(negedge clk);
    while (!scsi_ready) begin
      n++;
      if (n > TIMEOUT)
        stop_on_failure("SCSI word was never accepted by the FIFO");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    scsi_in.valid = 1'b0;
  endtask

  task automatic push_random(input int count);
    word_t w;
    for (int i = 0; i < count; i++) begin
      rand_word(w);
      sent.push_back(w);
      scsi_push(w);
    end
  endtask

  task automatic start_dma(input word_t addr, input word_t count, input word_t cntr);
    apb_write(`SDMAC_ACR, addr);
    apb_write(`SDMAC_WTC, count);
    apb_write(`SDMAC_CNTR, cntr);
    apb_write(`SDMAC_ST_DMA, 32'h0);
  endtask

  task automatic wait_int_low();
    int n;
    n = 0;
    @(negedge clk);
    while (int_n) begin
      n++;
      if (n > TIMEOUT)
        stop_on_failure("Interrupt output never went low");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // Sent words must sit in RAM in order from base
  task automatic check_dma_words(input string name, input logic [7:0] base);
    word_t d;
    for (int i = 0; i < sent.size(); i++) begin
      apb_read(win_addr(base + 8'(i)), d);
      check($sformatf("%s word %0d", name, i), sent[i], d);
    end
    sent.delete();
  endtask

  task automatic reset_state_test();
    word_t d;
    apb_read(`SDMAC_ISTR, d);
    check("reset istr", istr_value(1'b1, 1'b0, 1'b0, 1'b0), d);
    apb_read(`SDMAC_WTC, d);
    check("reset wtc", 32'h0, d);
    check("reset int_n", 32'h1, int_n);
  endtask

  task automatic window_test();
    word_t d;
    for (int i = 0; i < 4; i++) begin
      rand_word(win_words[i]);
      apb_write(win_addr(win_idx[i]), win_words[i]);
    end
    for (int i = 0; i < 4; i++) begin
      apb_read(win_addr(win_idx[i]), d);
      check("window readback", win_words[i], d);
    end
  endtask

  task automatic dma_transfer_test();
    word_t d;
    push_random(5);
    start_dma(32'h20, 32'd5, INTEN);
    wait_int_low();
    apb_read(`SDMAC_WTC, d);
    check("dma final wtc", 32'h0, d);
    apb_read(`SDMAC_ACR, d);
    check("dma final acr", 32'h25, d);
    check_dma_words("dma transfer", 8'h20);
  endtask

  task automatic status_clear_test();
    word_t d;
    int    n;
    apb_read(`SDMAC_ISTR, d);
    check("istr after dma", istr_value(1'b1, 1'b0, 1'b1, 1'b1), d);
    apb_write(`SDMAC_CLR_INT, 32'h0);
    check("int_n after clear", 32'h1, int_n);
    apb_read(`SDMAC_ISTR, d);
    check("istr after clear", istr_value(1'b1, 1'b0, 1'b0, 1'b0), d);
    // Second transfer with the interrupt disabled
    push_random(2);
    start_dma(32'h30, 32'd2, 32'h0);
    n = 0;
    apb_read(`SDMAC_ISTR, d);
    while (!d[`SDMAC_ISTR_INTS]) begin
      n++;
      if (n > TIMEOUT)
        stop_on_failure("Second transfer never set the interrupt status");
      apb_read(`SDMAC_ISTR, d);
    end
    check("istr without inten", istr_value(1'b1, 1'b0, 1'b0, 1'b1), d);
    check("int_n without inten", 32'h1, int_n);
    check_dma_words("second transfer", 8'h30);
    apb_write(`SDMAC_CLR_INT, 32'h0);
  endtask

  task automatic fifo_full_test();
    word_t d;
    push_random(`SDMAC_FIFO_DEPTH);
    check("scsi_ready when full", 32'h0, scsi_ready);
    apb_read(`SDMAC_ISTR, d);
    check("istr when full", istr_value(1'b0, 1'b1, 1'b0, 1'b0), d);
    start_dma(32'h40, `SDMAC_FIFO_DEPTH, INTEN);
    wait_int_low();
    apb_read(`SDMAC_ISTR, d);
    check("istr after drain", istr_value(1'b1, 1'b0, 1'b1, 1'b1), d);
    check_dma_words("fifo drain", 8'h40);
    apb_write(`SDMAC_CLR_INT, 32'h0);
  endtask

  task automatic contention_test();
    word_t d;
    word_t ww [4];
    for (int i = 0; i < 4; i++)
      rand_word(ww[i]);
    push_random(8);
    start_dma(32'h60, 32'd12, INTEN);
    // More SCSI words arrive while the window competes for RAM
    fork
      push_random(4);
      begin
        for (int i = 0; i < 4; i++)
          apb_write(win_addr(8'hA0 + 8'(i)), ww[i]);
        for (int i = 0; i < 4; i++) begin
          apb_read(win_addr(8'hA0 + 8'(i)), d);
          check("contention window write", ww[i], d);
        end
        for (int i = 0; i < 4; i++) begin
          apb_read(win_addr(win_idx[i]), d);
          check("contention window read", win_words[i], d);
        end
      end
    join
    wait_int_low();
    check_dma_words("contention dma", 8'h60);
    apb_read(`SDMAC_WTC, d);
    check("contention final wtc", 32'h0, d);
  endtask

  initial begin
    clk     = 1'b0;
    RESET_  = 1'b0;
    apb_req = '0;
    scsi_in = '0;
    lfsr    = 32'h694e2d63;
    repeat (8) @(posedge clk);
    #1;
    RESET_ = 1'b1;
    reset_state_test();
    window_test();
    dma_transfer_test();
    status_clear_test();
    fifo_full_test();
    contention_test();
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
src/sdmac_pkg.sv
src/sdmac_regs.sv
src/sdmac_istr.sv
src/dma_fifo.sv
src/dma_engine.sv
src/mem_arbiter.sv
src/local_ram.sv
src/sdmac_top.sv
verification/tb_sdmac.sv
